// ==== Makefile ====
# Verilator build and run for the AES-128 core.

VERILATOR ?= verilator
TOP       ?= tb_aes
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := SOME TESTS FAILED
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "test: failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "test: simulator exited with $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== aes_cipher.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_config.svh"

module aes_cipher import aes_pkg::*; (
    input  logic       clk,
    input  logic       res,
    input  logic       start,
    input  block_t     din,
    input  logic       key_ready,
    output round_idx_t rd_idx,
    input  block_t     rd_key,
    output logic       busy,
    output logic       done,
    output block_t     dout
);

    cipher_state_t state;
    round_idx_t    cnt;         // round number, also the key index.
    block_t        blk;         // working state.
    block_t        rnd_out;
    logic          last;
    logic          accept;
    logic          go;          // first key added, rounds start next.

    assign accept = start && key_ready && !busy && !go;
    assign last   = (cnt == round_idx_t'(`AES_ROUNDS));
    assign rd_idx = cnt;        // key 0 while waiting.

    aes_round u_round (
        .state_in  (blk),
        .round_key (rd_key),
        .last      (last),
        .state_out (rnd_out)
    );

    // ############################
    // round fsm.
    // ############################
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            cnt   <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
            go    <= 1'b0;
            dout  <= '0;
        end else begin
            done <= 1'b0;
            go   <= accept;
            case (state)
                IDLE, DONE: begin
                    if (go) begin
                        state <= ROUND;
                        cnt   <= round_idx_t'(1);
                        busy  <= 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                ROUND: begin
                    if (last) begin
                        state <= DONE;
                        cnt   <= '0;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        dout  <= rnd_out;   // held until the next block.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // initial key add, then one round per clock.
    always_ff @(posedge clk) begin
        if (accept) begin
            blk <= din ^ rd_key;
        end else if (state == ROUND) begin
            blk <= rnd_out;
        end
    end

    // ############################
    // checks.
    // ############################
    // ten round cycles before each done.
    a_done_after_last: assert property (@(posedge clk) disable iff (!res)
        done |-> $past(busy, `AES_ROUNDS) && !$past(busy, `AES_ROUNDS + 1));

    a_idle_not_busy: assert property (@(posedge clk) disable iff (!res)
        state == IDLE |-> !busy);

endmodule

`default_nettype wire

// ==== aes_config.svh ====
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// ############################
// aes-128 fixed sizes.
// ############################

`define AES_ROUNDS   10     // cipher rounds after the first key add.
`define AES_NUM_KEYS 11     // round keys 0 to 10.

// constant of the s-box affine map.
`define AES_AFFINE_C 8'h63

`endif

// ==== aes_key_expand.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_config.svh"

module aes_key_expand import aes_pkg::*; (
    input  logic       clk,
    input  logic       res,
    input  logic       load_key,
    input  block_t     key,
    input  logic       busy,
    output logic       wr_en,
    output round_idx_t wr_idx,
    output block_t     wr_key,
    output logic       key_ready
);

    block_t     rk;         // round key being written.
    block_t     rk_next;
    round_idx_t cnt;
    byte_t      rcon;
    logic       active;
    logic       accept;

    word_t w0, w1, w2, w3;
    word_t rot, sub, tmp;
    word_t n0, n1, n2, n3;

    assign accept = load_key && !busy;  // keys stay put during a block.

    // ############################
    // next round key.
    // ############################
    assign {w0, w1, w2, w3} = rk;
    assign rot = {w3[23:0], w3[31:24]}; // rotword.

    for (genvar i = 0; i < 4; i++) begin : g_sub
        aes_sbox u_sbox (
            .in  (rot[8*i +: 8]),
            .out (sub[8*i +: 8])
        );
    end

    assign tmp = sub ^ {rcon, 24'h000000};
    assign n0  = w0 ^ tmp;
    assign n1  = w1 ^ n0;
    assign n2  = w2 ^ n1;
    assign n3  = w3 ^ n2;
    assign rk_next = {n0, n1, n2, n3};

    // ############################
    // control.
    // ############################
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active    <= 1'b0;
            cnt       <= '0;
            rcon      <= '0;
            key_ready <= 1'b0;
        end else if (accept) begin
            active <= 1'b1;
            cnt    <= '0;
            rcon   <= 8'h01;
        end else if (active) begin
            cnt  <= cnt + 1'b1;
            rcon <= xtime(rcon);
            if (cnt == round_idx_t'(`AES_ROUNDS)) begin
                active    <= 1'b0;
                key_ready <= 1'b1;  // with the last write.
            end else begin
                key_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rk <= key;
        end else if (active) begin
            rk <= rk_next;
        end
    end

    assign wr_en  = active;
    assign wr_idx = cnt;
    assign wr_key = rk;

    a_wr_idx_range: assert property (@(posedge clk) disable iff (!res)
        wr_en |-> wr_idx <= round_idx_t'(`AES_ROUNDS));

endmodule

`default_nettype wire

// ==== aes_key_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_config.svh"

module aes_key_store import aes_pkg::*; (
    input  logic       clk,
    input  logic       res,
    input  logic       wr_en,
    input  round_idx_t wr_idx,
    input  block_t     wr_key,
    input  round_idx_t rd_idx,
    output block_t     rd_key
);

    block_t keys [`AES_NUM_KEYS];

    // ############################
    // write port.
    // ############################
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < `AES_NUM_KEYS; i++) begin
                keys[i] <= '0;
            end
        end else if (wr_en) begin
            keys[wr_idx] <= wr_key;
        end
    end

    // read port, straight from the registers.
    assign rd_key = (rd_idx < round_idx_t'(`AES_NUM_KEYS)) ? keys[rd_idx] : '0;

    a_wr_in_range: assert property (@(posedge clk) disable iff (!res)
        wr_en |-> wr_idx < round_idx_t'(`AES_NUM_KEYS));

endmodule

`default_nettype wire

// ==== aes_pkg.sv ====
`default_nettype none

package aes_pkg;

    // ############################
    // widths with a meaning.
    // ############################
    typedef logic [127:0] block_t;      // cipher block or round key.
    typedef logic [31:0]  word_t;       // key schedule word.
    typedef logic [7:0]   byte_t;
    typedef logic [3:0]   round_idx_t;  // round key index, 0 to 10.

    typedef enum logic [1:0] {
        IDLE,
        ROUND,
        DONE
    } cipher_state_t;

    // multiply by x in gf(2^8), reduced by the aes polynomial.
    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

`default_nettype wire

// ==== aes_round.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_round import aes_pkg::*; (
    input  block_t state_in,
    input  block_t round_key,
    input  logic   last,
    output block_t state_out
);

    // byte i is row i%4, column i/4, msb first.
    byte_t  sb [16];
    byte_t  sh [16];
    byte_t  mx [16];
    block_t mixed;

    // ############################
    // subbytes.
    // ############################
    for (genvar i = 0; i < 16; i++) begin : g_sub
        aes_sbox u_sbox (
            .in  (state_in[127-8*i -: 8]),
            .out (sb[i])
        );
    end

    // ############################
    // shiftrows.
    // ############################
    for (genvar c = 0; c < 4; c++) begin : g_col
        for (genvar r = 0; r < 4; r++) begin : g_row
            assign sh[r+4*c] = sb[r + 4*((c+r)%4)];   // row r rotates left by r.
        end
    end

    // ############################
    // mixcolumns.
    // ############################
    for (genvar c = 0; c < 4; c++) begin : g_mix
        assign mx[4*c]   = xtime(sh[4*c]) ^ xtime(sh[4*c+1]) ^ sh[4*c+1]
                         ^ sh[4*c+2] ^ sh[4*c+3];
        assign mx[4*c+1] = sh[4*c] ^ xtime(sh[4*c+1]) ^ xtime(sh[4*c+2])
                         ^ sh[4*c+2] ^ sh[4*c+3];
        assign mx[4*c+2] = sh[4*c] ^ sh[4*c+1] ^ xtime(sh[4*c+2])
                         ^ xtime(sh[4*c+3]) ^ sh[4*c+3];
        assign mx[4*c+3] = xtime(sh[4*c]) ^ sh[4*c] ^ sh[4*c+1]
                         ^ sh[4*c+2] ^ xtime(sh[4*c+3]);
    end

    // last round skips the mix.
    for (genvar i = 0; i < 16; i++) begin : g_pack
        assign mixed[127-8*i -: 8] = last ? sh[i] : mx[i];
    end

    assign state_out = mixed ^ round_key;   // addroundkey.

endmodule

`default_nettype wire

// ==== aes_sbox.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "aes_config.svh"

module aes_sbox import aes_pkg::*; (
    input  byte_t in,
    output byte_t out
);

    byte_t pw;      // running square, in^(2^k).
    byte_t inv;     // multiplicative inverse.

    // shift and add multiply in gf(2^8).
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t aa;
        p  = '0;
        aa = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ aa;
            end
            aa = xtime(aa);
        end
        return p;
    endfunction

    // ############################
    // inverse as in^254.
    // ############################
    // 254 = 2 + 4 + 8 + 16 + 32 + 64 + 128, so multiply the seven squares.
    // zero maps to zero on its own.
    always_comb begin
        pw  = in;
        inv = 8'h01;
        for (int k = 1; k < 8; k++) begin
            pw  = gf_mul(pw, pw);
            inv = gf_mul(inv, pw);
        end
    end

    // ############################
    // affine map.
    // ############################
    assign out = inv
               ^ {inv[6:0], inv[7]}
               ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]}
               ^ `AES_AFFINE_C;

endmodule

`default_nettype wire

// ==== aes_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_top import aes_pkg::*; (
    input  logic   clk,
    input  logic   res,
    input  logic   load_key,
    input  block_t key,
    input  logic   start,
    input  block_t din,
    output logic   key_ready,
    output logic   busy,
    output logic   done,
    output block_t dout
);

    logic       wr_en;
    round_idx_t wr_idx;
    block_t     wr_key;
    round_idx_t rd_idx;
    block_t     rd_key;

    aes_key_expand u_key_expand (
        .clk       (clk),
        .res       (res),
        .load_key  (load_key),
        .key       (key),
        .busy      (busy),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_key    (wr_key),
        .key_ready (key_ready)
    );

    aes_key_store u_key_store (
        .clk    (clk),
        .res    (res),
        .wr_en  (wr_en),
        .wr_idx (wr_idx),
        .wr_key (wr_key),
        .rd_idx (rd_idx),
        .rd_key (rd_key)
    );

    aes_cipher u_cipher (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .din       (din),
        .key_ready (key_ready),
        .rd_idx    (rd_idx),
        .rd_key    (rd_key),
        .busy      (busy),
        .done      (done),
        .dout      (dout)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
aes_pkg.sv
aes_sbox.sv
aes_key_expand.sv
aes_key_store.sv
aes_round.sv
aes_cipher.sv
aes_top.sv
tb_aes.sv

// ==== tb_aes.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_aes import aes_pkg::*;;

    localparam int TIMEOUT        = 50;    // cycles per wait.
    localparam int KEY_LATENCY    = 11;    // load edge to key_ready.
    localparam int CIPHER_LATENCY = 11;    // start edge to done.

    localparam block_t C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t C1_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam block_t B_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam block_t B_PT   = 128'h3243f6a8885a308d313198a2e0370734;
    localparam block_t B_CT   = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam block_t B2_PT  = 128'h6bc1bee22e409f96e93d7e117393172a;
    localparam block_t B2_CT  = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
    localparam block_t Z_CT   = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    logic   clk;
    logic   res;
    logic   load_key;
    block_t key;
    logic   start;
    block_t din;
    logic   key_ready;
    logic   busy;
    logic   done;
    block_t dout;

    int    test_count;
    int    fail_count;
    int    err_count;
    string test_name;

    aes_top u_dut (
        .clk       (clk),
        .res       (res),
        .load_key  (load_key),
        .key       (key),
        .start     (start),
        .din       (din),
        .key_ready (key_ready),
        .busy      (busy),
        .done      (done),
        .dout      (dout)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ############################
    // checking and bookkeeping.
    // ############################
    task automatic check(input string what, input block_t expected, input block_t actual);
        if (expected !== actual) begin
            $display("** Error %s: %s expected %h, actual %h", test_name, what, expected,
                     actual);
            err_count++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s: %s", test_name, msg);
        err_count++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_count = 0;
        test_count++;
    endtask

    task automatic end_test;
        if (err_count == 0) begin
            $display("%s passed", test_name);
        end else begin
            $display("%s failed with %0d errors", test_name, err_count);
            fail_count++;
        end
    endtask

    // ############################
    // driving.
    // ############################
    task automatic drive_idle;
        load_key = 1'b0;
        start    = 1'b0;
        key      = '0;
        din      = '0;
    endtask

    task automatic apply_reset;
        res = 1'b0;
        drive_idle();
        repeat (4) @(negedge clk);
        res = 1'b1;
    endtask

    task automatic load_key_pulse(input block_t k);
        @(negedge clk);
        key      = k;
        load_key = 1'b1;
        @(negedge clk);
        load_key = 1'b0;
    endtask

    task automatic start_pulse(input block_t pt);
        @(negedge clk);
        din   = pt;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_key_ready(output int cycles, output bit ok);
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (key_ready) ok = 1'b1;
        end
    endtask

    // optionally checks that dout holds its old value until done.
    task automatic wait_done(input bit hold, input block_t hold_val, output int cycles,
                             output bit ok);
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                ok = 1'b1;
            end else if (hold) begin
                check("dout held", hold_val, dout);
            end
        end
    endtask

    task automatic load_and_wait(input block_t k, output int cycles, output bit ok);
        load_key_pulse(k);
        wait_key_ready(cycles, ok);
        if (!ok) note_failure("key_ready did not rise within the timeout");
    endtask

    task automatic encrypt_block(input block_t pt, output int cycles, output bit ok);
        start_pulse(pt);
        wait_done(1'b0, '0, cycles, ok);
        if (!ok) note_failure("no done within the timeout");
    endtask

    // ############################
    // tests.
    // ############################
    task automatic reset_state;
        begin_test("reset_state");
        apply_reset();
        check("key_ready", '0, block_t'(key_ready));
        check("busy", '0, block_t'(busy));
        check("done", '0, block_t'(done));
        check("dout", '0, dout);
        end_test();
    endtask

    task automatic start_without_key;
        int cyc;
        bit ok;
        begin_test("start_without_key");
        start_pulse(C1_PT);
        wait_done(1'b0, '0, cyc, ok);
        if (ok) note_failure("done appeared although no key was loaded");
        check("busy", '0, block_t'(busy));
        end_test();
    endtask

    task automatic fips_c1_vector;
        int cyc;
        bit ok;
        begin_test("fips_c1_vector");
        load_and_wait(C1_KEY, cyc, ok);
        if (ok) check("key latency", block_t'(KEY_LATENCY), block_t'(cyc));
        encrypt_block(C1_PT, cyc, ok);
        if (ok) begin
            check("done latency", block_t'(CIPHER_LATENCY), block_t'(cyc));
            check("dout", C1_CT, dout);
            @(negedge clk);
            check("done width", '0, block_t'(done));   // one cycle only.
        end
        end_test();
    endtask

    task automatic key_reuse;
        int cyc;
        bit ok;
        begin_test("key_reuse");
        load_and_wait(B_KEY, cyc, ok);
        encrypt_block(B_PT, cyc, ok);
        check("first dout", B_CT, dout);
        repeat (2) @(negedge clk);
        check("first dout kept", B_CT, dout);
        start_pulse(B2_PT);
        wait_done(1'b1, B_CT, cyc, ok);
        if (!ok) note_failure("no done for the second block within the timeout");
        check("second dout", B2_CT, dout);
        end_test();
    endtask

    task automatic strobes_while_busy;
        int cyc;
        bit ok;
        begin_test("strobes_while_busy");
        start_pulse(B_PT);
        repeat (2) @(negedge clk);
        check("busy", block_t'(1'b1), block_t'(busy));
        din      = B2_PT;
        start    = 1'b1;
        key      = '0;
        load_key = 1'b1;
        @(negedge clk);
        start    = 1'b0;
        load_key = 1'b0;
        wait_done(1'b0, '0, cyc, ok);
        if (!ok) note_failure("block in flight gave no done within the timeout");
        check("dout", B_CT, dout);
        check("key_ready", block_t'(1'b1), block_t'(key_ready));
        repeat (2) @(negedge clk);
        check("done after drop", '0, block_t'(done));
        check("busy after drop", '0, block_t'(busy));
        // old key still in place.
        encrypt_block(B2_PT, cyc, ok);
        check("next dout", B2_CT, dout);
        end_test();
    endtask

    task automatic key_change;
        int cyc;
        bit ok;
        begin_test("key_change");
        load_and_wait('0, cyc, ok);
        encrypt_block('0, cyc, ok);
        check("dout", Z_CT, dout);
        end_test();
    endtask

    task automatic reset_mid_block;
        int cyc;
        bit ok;
        begin_test("reset_mid_block");
        load_and_wait(C1_KEY, cyc, ok);
        start_pulse(C1_PT);
        repeat (3) @(negedge clk);
        check("busy before reset", block_t'(1'b1), block_t'(busy));
        res = 1'b0;
        @(negedge clk);
        check("busy in reset", '0, block_t'(busy));
        check("done in reset", '0, block_t'(done));
        check("key_ready in reset", '0, block_t'(key_ready));
        check("dout in reset", '0, dout);
        repeat (3) @(negedge clk);
        res = 1'b1;
        @(negedge clk);
        check("key_ready after reset", '0, block_t'(key_ready));
        start_pulse(C1_PT);
        wait_done(1'b0, '0, cyc, ok);
        if (ok) note_failure("done appeared after reset without a new key");
        check("busy after reset", '0, block_t'(busy));
        load_and_wait(C1_KEY, cyc, ok);   // back to work.
        encrypt_block(C1_PT, cyc, ok);
        check("dout after reload", C1_CT, dout);
        end_test();
    endtask

    // ############################
    // main sequence.
    // ############################
    initial begin
        res        = 1'b0;
        load_key   = 1'b0;
        key        = '0;
        start      = 1'b0;
        din        = '0;
        test_count = 0;
        fail_count = 0;
        err_count  = 0;
        test_name  = "";

        reset_state();
        start_without_key();
        fips_c1_vector();
        key_reuse();
        strobes_while_busy();
        key_change();
        reset_mid_block();

        $display("%0d tests run, %0d failed", test_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
